// ==== timer_pkg.sv ====
/*
 * Shared constants for the AXI4-Lite timer.
 * Holds the data and address widths, the register map, the CTRL and
 * STATUS bit positions and the bus response code.
 * Imported by the interfaces and every RTL module.
 */
package timer_pkg;

    // Widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 6;
    localparam int PRE_W  = 16;
    localparam int CTRL_W = 8;
    localparam int STAT_W = 2;

    // Register map, byte offsets
    localparam logic [ADDR_W-1:0] REG_CTRL    = 6'h00;
    localparam logic [ADDR_W-1:0] REG_PRE     = 6'h04;
    localparam logic [ADDR_W-1:0] REG_LOAD    = 6'h08;
    localparam logic [ADDR_W-1:0] REG_CMP     = 6'h0C;
    localparam logic [ADDR_W-1:0] REG_CURRENT = 6'h10;
    localparam logic [ADDR_W-1:0] REG_CAPTURE = 6'h14;
    localparam logic [ADDR_W-1:0] REG_STATUS  = 6'h18;
    localparam logic [ADDR_W-1:0] REG_CMD     = 6'h1C;

    // CTRL bit positions
    localparam int CTRL_EN     = 0;
    localparam int CTRL_MODE   = 1;
    localparam int CTRL_DIR    = 2;
    localparam int CTRL_PWM_EN = 3;
    localparam int CTRL_EXT_EN = 4;
    localparam int CTRL_CAP_EN = 5;
    localparam int CTRL_PRE_EN = 6;
    localparam int CTRL_IRQ_EN = 7;

    // STATUS bit positions
    localparam int STAT_WRAP = 0;
    localparam int STAT_CAP  = 1;

    // AXI response code
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== timer_if.sv ====
/*
 * Internal buses of the timer.
 * timer_bus_if carries register accesses from the AXI slave to the
 * register file, timer_ctrl_if carries settings and strobes between the
 * register file and the counter core.
 */
`timescale 1ns/1ps

interface timer_bus_if import timer_pkg::*; ();
    logic              cs;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;

    modport axi  (output cs, we, addr, wdata, input rdata);
    modport regs (input cs, we, addr, wdata, output rdata);
endinterface

interface timer_ctrl_if import timer_pkg::*; ();
    // Settings from the register file
    logic              en;
    logic              mode;
    logic              dir;
    logic              pwm_en;
    logic              ext_en;
    logic              cap_en;
    logic              pre_en;
    logic [PRE_W-1:0]  pre_val;
    logic [DATA_W-1:0] load_val;
    logic [DATA_W-1:0] cmp_val;
    logic              load_cmd;
    // Counter state back to the register file
    logic [DATA_W-1:0] current_val;
    logic [DATA_W-1:0] capture_val;
    logic              capture_stb;
    logic              wrap_stb;

    modport regs (
        output en, mode, dir, pwm_en, ext_en, cap_en, pre_en,
        output pre_val, load_val, cmp_val, load_cmd,
        input  current_val, capture_val, capture_stb, wrap_stb
    );
    modport core (
        input  en, mode, dir, pwm_en, ext_en, cap_en, pre_en,
        input  pre_val, load_val, cmp_val, load_cmd,
        output current_val, capture_val, capture_stb, wrap_stb
    );
endinterface

// ==== timer_prescaler.sv ====
/*
 * Clock prescaler for the timer core.
 * Gives a one-cycle tick every pre_val_i+1 clocks when pre_en_i is set,
 * and every clock otherwise. Idle and cleared while en_i is low.
 */
`timescale 1ns/1ps

module timer_prescaler import timer_pkg::*; (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             en_i,
    input  logic             pre_en_i,
    input  logic [PRE_W-1:0] pre_val_i,
    output logic             tick_o
);

    logic [PRE_W-1:0] cnt;

    // Count down from pre_val_i, tick on zero
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt <= '0;
        end else if (!en_i || !pre_en_i) begin
            cnt <= '0;
        end else if (cnt == '0) begin
            cnt <= pre_val_i;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    // Bypass when the prescaler is off
    assign tick_o = en_i && (!pre_en_i || (cnt == '0));

endmodule

// ==== timer_core.sv ====
/*
 * Timer counter core.
 * Counts prescaled clock ticks or rising edges of ext_meas_i, up or down,
 * periodic or one-shot. Drives PWM, the trigger pulse and the capture
 * register, and reports wrap and capture strobes to the register file.
 */
`timescale 1ns/1ps

module timer_core import timer_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    timer_ctrl_if.core ctrl,
    input  logic       ext_meas_i,
    input  logic       capture_i,
    output logic       pwm_o,
    output logic       trigger_o
);

    // Pin pipeline, bit 0 is ext_meas_i and bit 1 is capture_i
    logic [1:0]        pin_s1;
    logic [1:0]        pin_s2;
    logic [1:0]        pin_s3;
    logic [1:0]        pin_rise;

    logic              pre_tick;
    logic              tick;
    logic              count_en;
    logic              at_end;
    logic              os_done;
    logic [DATA_W-1:0] cnt;
    logic              wrap_q;
    logic              pwm_q;
    logic              cap_stb_q;
    logic [DATA_W-1:0] cap_q;

    // Two-flop synchronizers plus one stage for edge detection
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pin_s1 <= '0;
            pin_s2 <= '0;
            pin_s3 <= '0;
        end else begin
            pin_s1 <= {capture_i, ext_meas_i};
            pin_s2 <= pin_s1;
            pin_s3 <= pin_s2;
        end
    end

    assign pin_rise = pin_s2 & ~pin_s3;

    // Prescaler idles while counting external edges
    timer_prescaler i_prescaler (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .en_i      (ctrl.en && !ctrl.ext_en),
        .pre_en_i  (ctrl.pre_en),
        .pre_val_i (ctrl.pre_val),
        .tick_o    (pre_tick)
    );

    assign tick     = ctrl.ext_en ? pin_rise[0] : pre_tick;
    // A finished one-shot ignores ticks until the next load command
    assign count_en = ctrl.en && tick && !(ctrl.mode && os_done);
    assign at_end   = ctrl.dir ? (cnt >= ctrl.load_val) : (cnt == '0);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cnt     <= '0;
            os_done <= 1'b0;
            wrap_q  <= 1'b0;
        end else begin
            wrap_q <= 1'b0;
            if (ctrl.load_cmd) begin
                cnt     <= ctrl.dir ? '0 : ctrl.load_val;
                os_done <= 1'b0;
            end else if (count_en) begin
                if (at_end) begin
                    wrap_q <= 1'b1;
                    if (ctrl.mode) begin
                        // One-shot end, park at the terminal value
                        os_done <= 1'b1;
                        cnt     <= ctrl.dir ? ctrl.load_val : '0;
                    end else begin
                        cnt <= ctrl.dir ? '0 : ctrl.load_val;
                    end
                end else begin
                    cnt <= ctrl.dir ? cnt + 1'b1 : cnt - 1'b1;
                end
            end
        end
    end

    // PWM compare and capture strobe
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            pwm_q     <= 1'b0;
            cap_stb_q <= 1'b0;
        end else begin
            pwm_q     <= ctrl.pwm_en && (cnt < ctrl.cmp_val);
            cap_stb_q <= ctrl.cap_en && pin_rise[1];
        end
    end

    always_ff @(posedge aclk) begin
        if (ctrl.cap_en && pin_rise[1]) begin
            cap_q <= cnt;
        end
    end

    assign ctrl.current_val = cnt;
    assign ctrl.capture_val = cap_q;
    assign ctrl.capture_stb = cap_stb_q;
    assign ctrl.wrap_stb    = wrap_q;
    assign trigger_o        = wrap_q;
    assign pwm_o            = pwm_q;

    // No capture strobe while capture is disabled
    a_cap_needs_en: assert property (@(posedge aclk) disable iff (!aresetn)
        ctrl.capture_stb |-> ctrl.cap_en);

endmodule

// ==== timer_regs.sv ====
/*
 * Timer register file.
 * Decodes bus writes into CTRL, PRE, LOAD and CMP, turns a CMD write into
 * a load pulse, keeps the sticky STATUS bits with write-one-to-clear and
 * drives the interrupt. Reads are combinational from the bus address.
 */
`timescale 1ns/1ps

module timer_regs import timer_pkg::*; (
    input  logic       aclk,
    input  logic       aresetn,
    timer_bus_if.regs  bus,
    timer_ctrl_if.regs ctrl,
    output logic       irq_o
);

    logic              wr;
    logic [CTRL_W-1:0] ctrl_q;
    logic [PRE_W-1:0]  pre_q;
    logic [DATA_W-1:0] load_q;
    logic [DATA_W-1:0] cmp_q;
    logic              load_cmd_q;
    logic [STAT_W-1:0] stat_q;
    logic [STAT_W-1:0] stat_set;
    logic [STAT_W-1:0] stat_clr;
    logic              irq_q;

    assign wr = bus.cs && bus.we;

    // Writable registers and the load command pulse
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ctrl_q     <= '0;
            pre_q      <= '0;
            load_q     <= '0;
            cmp_q      <= '0;
            load_cmd_q <= 1'b0;
        end else begin
            load_cmd_q <= wr && (bus.addr == REG_CMD) && bus.wdata[0];
            if (wr) begin
                case (bus.addr)
                    REG_CTRL: ctrl_q <= bus.wdata[CTRL_W-1:0];
                    REG_PRE:  pre_q  <= bus.wdata[PRE_W-1:0];
                    REG_LOAD: load_q <= bus.wdata;
                    REG_CMP:  cmp_q  <= bus.wdata;
                    default:  ;
                endcase
            end
        end
    end

    always_comb begin
        stat_set            = '0;
        stat_set[STAT_WRAP] = ctrl.wrap_stb;
        stat_set[STAT_CAP]  = ctrl.capture_stb;
    end

    assign stat_clr = (wr && (bus.addr == REG_STATUS)) ? bus.wdata[STAT_W-1:0] : '0;

    // Sticky status, a new event beats a clear in the same cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            stat_q <= '0;
            irq_q  <= 1'b0;
        end else begin
            stat_q <= (stat_q & ~stat_clr) | stat_set;
            irq_q  <= ctrl_q[CTRL_IRQ_EN] && (|stat_q);
        end
    end

    // Read mux, unmapped and write-only offsets read as zero
    always_comb begin
        case (bus.addr)
            REG_CTRL:    bus.rdata = DATA_W'(ctrl_q);
            REG_PRE:     bus.rdata = DATA_W'(pre_q);
            REG_LOAD:    bus.rdata = load_q;
            REG_CMP:     bus.rdata = cmp_q;
            REG_CURRENT: bus.rdata = ctrl.current_val;
            REG_CAPTURE: bus.rdata = ctrl.capture_val;
            REG_STATUS:  bus.rdata = DATA_W'(stat_q);
            default:     bus.rdata = '0;
        endcase
    end

    assign ctrl.en       = ctrl_q[CTRL_EN];
    assign ctrl.mode     = ctrl_q[CTRL_MODE];
    assign ctrl.dir      = ctrl_q[CTRL_DIR];
    assign ctrl.pwm_en   = ctrl_q[CTRL_PWM_EN];
    assign ctrl.ext_en   = ctrl_q[CTRL_EXT_EN];
    assign ctrl.cap_en   = ctrl_q[CTRL_CAP_EN];
    assign ctrl.pre_en   = ctrl_q[CTRL_PRE_EN];
    assign ctrl.pre_val  = pre_q;
    assign ctrl.load_val = load_q;
    assign ctrl.cmp_val  = cmp_q;
    assign ctrl.load_cmd = load_cmd_q;
    assign irq_o         = irq_q;

    // The AXI side never issues back-to-back writes, so the pulse is single
    a_load_cmd_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        ctrl.load_cmd |=> !ctrl.load_cmd);

endmodule

// ==== timer_axi.sv ====
/*
 * General purpose timer with an AXI4-Lite slave port.
 * Handles single-beat write and read transfers, turns them into register
 * strobes, and instantiates the register file and the counter core.
 * Address and data of a write must arrive together.
 */
`timescale 1ns/1ps

module timer_axi import timer_pkg::*; (
    input  logic              aclk,
    input  logic              aresetn,
    // Write address channel
    input  logic [DATA_W-1:0] awaddr_i,
    input  logic [2:0]        awprot_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    // Write data channel
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [3:0]        wstrb_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    // Write response channel
    output logic [1:0]        bresp_o,
    output logic              bvalid_o,
    input  logic              bready_i,
    // Read address channel
    input  logic [DATA_W-1:0] araddr_i,
    input  logic [2:0]        arprot_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    // Read data channel
    output logic [DATA_W-1:0] rdata_o,
    output logic [1:0]        rresp_o,
    output logic              rvalid_o,
    input  logic              rready_i,
    // Timer pins
    input  logic              ext_meas_i,
    input  logic              capture_i,
    output logic              pwm_o,
    output logic              trigger_o,
    output logic              irq_o
);

    timer_bus_if  bus_if ();
    timer_ctrl_if ctrl_if ();

    logic              wr_go;
    logic              rd_go;
    logic              wr_hs;
    logic              rd_hs;
    logic              wr_acc_q;
    logic              arready_q;
    logic              bvalid_q;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;

    // Accept conditions, a pending write blocks the read accept
    assign wr_go = awvalid_i && wvalid_i && !wr_acc_q && !bvalid_q;
    assign rd_go = arvalid_i && !arready_q && !rvalid_q && !wr_go;
    assign wr_hs = awvalid_i && wvalid_i && wr_acc_q;
    assign rd_hs = arvalid_i && arready_q;

    // Write channel
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_acc_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_acc_q <= wr_go;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Read channel
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= rd_go;
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Read data held until the master takes it
    always_ff @(posedge aclk) begin
        if (rd_hs) begin
            rdata_q <= bus_if.rdata;
        end
    end

    // Register strobe, write address takes priority
    assign bus_if.cs    = wr_hs || rd_hs;
    assign bus_if.we    = wr_hs;
    assign bus_if.addr  = wr_hs ? awaddr_i[ADDR_W-1:0] : araddr_i[ADDR_W-1:0];
    assign bus_if.wdata = wdata_i;

    assign awready_o = wr_acc_q;
    assign wready_o  = wr_acc_q;
    assign bvalid_o  = bvalid_q;
    assign bresp_o   = RESP_OKAY;
    assign arready_o = arready_q;
    assign rvalid_o  = rvalid_q;
    assign rdata_o   = rdata_q;
    assign rresp_o   = RESP_OKAY;

    timer_regs i_timer_regs (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (bus_if.regs),
        .ctrl    (ctrl_if.regs),
        .irq_o   (irq_o)
    );

    timer_core i_timer_core (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .ctrl       (ctrl_if.core),
        .ext_meas_i (ext_meas_i),
        .capture_i  (capture_i),
        .pwm_o      (pwm_o),
        .trigger_o  (trigger_o)
    );

    // Response held and no new write taken until the master accepts it
    a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid_o && !bready_i |=> bvalid_o && !awready_o);

endmodule

// ==== tb_timer_axi.sv ====
/*
 * Self-checking testbench for the AXI4-Lite timer.
 * Walks a register table over AXI, then checks periodic, one-shot, PWM,
 * external count, capture and interrupt behavior against expected values.
 */
`timescale 1ns/1ps

module tb_timer_axi import timer_pkg::*; ();

    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] mask;
    } entry_t;

    localparam int TBL_N = 11;
    // Accesses made by tests 2 to 6
    localparam int N_ACC = 42;
    localparam int L3    = 10;
    localparam int L4    = 9;
    localparam int C4    = 4;
    localparam int N0    = 50;
    localparam int K     = 7;
    localparam int L6    = 5;

    // Columns are write flag, offset, write data, expected read data, compare mask
    localparam entry_t TBL [TBL_N] = '{
        '{1'b0, REG_CTRL,    32'h0,         32'h0,         32'hFFFF_FFFF},
        '{1'b1, REG_PRE,     32'hABCD_0003, 32'h0,         32'h0},
        '{1'b1, REG_LOAD,    32'h1234_5678, 32'h0,         32'h0},
        '{1'b1, REG_CMP,     32'h0000_0155, 32'h0,         32'h0},
        '{1'b0, REG_PRE,     32'h0,         32'h0000_0003, 32'hFFFF_FFFF},
        '{1'b0, REG_LOAD,    32'h0,         32'h1234_5678, 32'hFFFF_FFFF},
        '{1'b0, REG_CMP,     32'h0,         32'h0000_0155, 32'hFFFF_FFFF},
        '{1'b1, REG_CMD,     32'h1,         32'h0,         32'h0},
        '{1'b0, REG_CURRENT, 32'h0,         32'h1234_5678, 32'hFFFF_FFFF},
        '{1'b0, 6'h20,       32'h0,         32'h0,         32'hFFFF_FFFF},
        '{1'b0, 6'h3C,       32'h0,         32'h0,         32'hFFFF_FFFF}
    };

    logic              aclk;
    logic              aresetn;
    logic [DATA_W-1:0] awaddr_i, wdata_i, araddr_i, rdata_o;
    logic [2:0]        awprot_i, arprot_i;
    logic [3:0]        wstrb_i;
    logic [1:0]        bresp_o, rresp_o;
    logic              awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    logic              awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    logic              ext_meas_i, capture_i, pwm_o, trigger_o, irq_o;
    // Bit 0 drives ext_meas_i, bit 1 drives capture_i
    logic [1:0]        pins;

    int          errors   = 0;
    int          n_tests  = 0;
    int          n_failed = 0;
    int          cycles   = 0;
    int          limit;
    int unsigned rl [3];
    int unsigned rp [3];

    assign {capture_i, ext_meas_i} = pins;

    timer_axi i_timer_axi (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // Watchdog on the whole run
    always @(posedge aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: no DUT response or trigger within %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s = 0x%h, expected 0x%h",
                     $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge aclk);
        awaddr_i  = DATA_W'(addr);
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        do @(negedge aclk); while (!awready_o);
        check("wready_o", 32'(wready_o), 32'h1);
        @(negedge aclk);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        while (!bvalid_o) @(negedge aclk);
        check("bresp_o", 32'(bresp_o), 32'(RESP_OKAY));
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(negedge aclk);
        araddr_i  = DATA_W'(addr);
        arvalid_i = 1'b1;
        do @(negedge aclk); while (!arready_o);
        @(negedge aclk);
        arvalid_i = 1'b0;
        while (!rvalid_o) @(negedge aclk);
        data = rdata_o;
        check("rresp_o", 32'(rresp_o), 32'(RESP_OKAY));
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr, input string name,
                              input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] mask);
        logic [DATA_W-1:0] data;
        axi_read(addr, data);
        check(name, data & mask, exp & mask);
    endtask

    // Clocks until the next trigger pulse
    task automatic wait_trigger(output int n);
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!trigger_o);
    endtask

    task automatic count_pulses(input int n, output int trig, output int pwm_hi);
        trig   = 0;
        pwm_hi = 0;
        repeat (n) begin
            @(negedge aclk);
            trig   += trigger_o;
            pwm_hi += pwm_o;
        end
    endtask

    // Two clocks high, at least two low, then time for the synchronizer
    task automatic pulse_pin(input int sel, input int count);
        repeat (count) begin
            @(negedge aclk);
            pins[sel] = 1'b1;
            repeat (2) @(negedge aclk);
            pins[sel] = 1'b0;
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        n_tests++;
        if (errors != err_before) begin
            n_failed++;
        end
        $display("Test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int n, trig, hi, err0;
        void'($urandom(32'h9cb6340e));
        foreach (rl[i]) begin
            rl[i] = 2 + $urandom % 19;
            rp[i] = $urandom % 4;
        end
        limit = 200 * (TBL_N + N_ACC) + 3 * (L3 + 1) + 3 * (L4 + 1) + 4 * (K + 3)
              + 2 * (L6 + 1) + 20;
        foreach (rl[i]) begin
            limit += 3 * (rl[i] + 1) * (rp[i] + 1);
        end
        aresetn   = 1'b0;
        awaddr_i  = '0;
        awprot_i  = '0;
        awvalid_i = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '1;
        wvalid_i  = 1'b0;
        bready_i  = 1'b1;
        araddr_i  = '0;
        arprot_i  = '0;
        arvalid_i = 1'b0;
        rready_i  = 1'b1;
        pins      = '0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        err0 = errors;
        check("reset outputs", {awready_o, wready_o, bvalid_o, arready_o, rvalid_o,
                                pwm_o, trigger_o, irq_o}, 0);
        for (int i = 0; i < TBL_N; i++) begin
            if (TBL[i].wr) begin
                axi_write(TBL[i].addr, TBL[i].data);
            end else begin
                read_check(TBL[i].addr, "rdata_o", TBL[i].exp, TBL[i].mask);
            end
        end
        end_test(1, "register access", err0);

        // Period is (load+1)*(pre+1) clocks
        err0 = errors;
        foreach (rl[i]) begin
            axi_write(REG_CTRL, 0);
            axi_write(REG_PRE, rp[i]);
            axi_write(REG_LOAD, rl[i]);
            axi_write(REG_CMD, 1);
            axi_write(REG_CTRL, (1 << CTRL_EN) | (1 << CTRL_PRE_EN));
            wait_trigger(n);
            repeat (2) begin
                wait_trigger(n);
                check("trigger_o period", n, (rl[i] + 1) * (rp[i] + 1));
            end
        end
        end_test(2, "periodic down count", err0);

        err0 = errors;
        axi_write(REG_CTRL, 1 << CTRL_DIR);
        axi_write(REG_LOAD, L3);
        axi_write(REG_CMD, 1);
        axi_write(REG_CTRL, (1 << CTRL_EN) | (1 << CTRL_MODE) | (1 << CTRL_DIR));
        wait_trigger(n);
        read_check(REG_CURRENT, "CURRENT", L3, '1);
        count_pulses(2 * (L3 + 1), trig, hi);
        check("trigger_o pulses", trig, 0);
        read_check(REG_CURRENT, "CURRENT", L3, '1);
        end_test(3, "one-shot up count", err0);

        err0 = errors;
        axi_write(REG_CTRL, 1 << CTRL_DIR);
        axi_write(REG_LOAD, L4);
        axi_write(REG_CMP, C4);
        axi_write(REG_CMD, 1);
        axi_write(REG_CTRL, (1 << CTRL_EN) | (1 << CTRL_DIR) | (1 << CTRL_PWM_EN));
        wait_trigger(n);
        count_pulses(L4 + 1, trig, hi);
        check("pwm_o high cycles", hi, C4);
        axi_write(REG_CTRL, (1 << CTRL_EN) | (1 << CTRL_DIR));
        count_pulses(L4 + 1, trig, hi);
        check("pwm_o high cycles", hi, 0);
        end_test(4, "PWM", err0);

        err0 = errors;
        axi_write(REG_CTRL, 0);
        axi_write(REG_LOAD, N0);
        axi_write(REG_CMD, 1);
        axi_write(REG_CTRL, (1 << CTRL_EN) | (1 << CTRL_EXT_EN) | (1 << CTRL_CAP_EN));
        pulse_pin(0, K);
        read_check(REG_CURRENT, "CURRENT", N0 - K, '1);
        pulse_pin(1, 1);
        read_check(REG_CAPTURE, "CAPTURE", N0 - K, '1);
        read_check(REG_STATUS, "STATUS", 1 << STAT_CAP, 1 << STAT_CAP);
        end_test(5, "external count and capture", err0);

        err0 = errors;
        axi_write(REG_CTRL, 0);
        axi_write(REG_STATUS, (1 << STAT_WRAP) | (1 << STAT_CAP));
        axi_write(REG_LOAD, L6);
        axi_write(REG_CMD, 1);
        axi_write(REG_CTRL, (1 << CTRL_EN) | (1 << CTRL_IRQ_EN));
        check("irq_o", irq_o, 0);
        wait_trigger(n);
        // Status then irq_o are registered after the wrap
        repeat (3) @(negedge aclk);
        check("irq_o", irq_o, 1);
        axi_write(REG_CTRL, 1 << CTRL_IRQ_EN);
        axi_write(REG_STATUS, (1 << STAT_WRAP) | (1 << STAT_CAP));
        read_check(REG_STATUS, "STATUS", 0, '1);
        check("irq_o", irq_o, 0);
        end_test(6, "interrupt", err0);

        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
timer_pkg.sv
timer_if.sv
timer_prescaler.sv
timer_core.sv
timer_regs.sv
timer_axi.sv
tb_timer_axi.sv
